// File: verification/bsx_trace.txt
# kind a b op result status resp, all hex; status is carry,zero,done,busy in bits 3..0
# kind 0 op, 1 CMD write, 2 write to offset a, 3 read offset a, 4 command while busy
0 00000005 00000007 0 0000000C 2 0
0 FFFFFFFF 00000001 0 00000000 E 0
0 7FFFFFFF 00000001 0 80000000 2 0
0 00000010 00000003 1 0000000D A 0
0 00000003 00000010 1 FFFFFFF3 2 0
0 00001234 00001234 1 00000000 E 0
0 F0F0F0F0 FF00FF00 2 F000F000 2 0
0 0F0F0000 0000F0F0 3 0F0FF0F0 2 0
0 A5A5A5A5 A5A5A5A5 4 00000000 6 0
0 12345678 FFFFFFFF 4 EDCBA987 2 0
0 80000000 00000001 5 00000001 A 0
0 80000000 00000001 6 00000000 E 0
0 00000001 80000000 5 00000000 6 0
0 00000001 80000000 6 00000001 2 0
0 FFFFFFFF 00000000 5 00000001 A 0
0 7FFFFFFF 80000000 5 00000000 6 0
0 00000005 00000005 6 00000000 E 0
1 00000000 00000000 7 00000000 E 2
2 00000014 DEADBEEF 0 00000000 E 2
2 0000000C 00000001 0 00000000 E 0
3 00000020 00000000 0 00000000 0 2
3 00000000 00000000 0 00000005 0 0
4 00000100 00000200 0 00000300 2 2
0 FFFFFFFE FFFFFFFF 1 FFFFFFFF 2 0

// File: list.f
rtl/bsx_pkg.sv
rtl/bsx_axil_regs.sv
rtl/bsx_sequencer.sv
rtl/bsx_serial_alu.sv
rtl/bsx_result_collector.sv
rtl/bsx_top.sv
verification/bsx_checker.sv
verification/bsx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the bsx testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module bsx_tb -o bsx_sim \
   > build.log 2>&1 \
   && ./obj_dir/bsx_sim > sim.log 2>&1 \
   || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Regression failed" sim.log \
   && { cat sim.log; exit 1; } \
   || { cat sim.log; exit 0; }

// File: verification/bsx_tb.sv
`timescale 1ns/1ps

module bsx_tb import bsx_pkg::*;;

   localparam int W          = 1;
   localparam int TIMEOUT    = 100;
   localparam int POLL_LIMIT = 40;
   localparam logic [1:0] OKAY   = 2'b00;

   logic                i_clk;
   logic                i_rst;
   logic                i_awvalid;
   logic                o_awready;
   logic [7:0]          i_awaddr;
   logic                i_wvalid;
   logic                o_wready;
   logic [DATA_W-1:0]   i_wdata;
   logic [DATA_W/8-1:0] i_wstrb;
   logic                o_bvalid;
   logic                i_bready;
   logic [1:0]          o_bresp;
   logic                i_arvalid;
   logic                o_arready;
   logic [7:0]          i_araddr;
   logic                o_rvalid;
   logic                i_rready;
   logic [DATA_W-1:0]   o_rdata;
   logic [1:0]          o_rresp;

   // expectations handed to the checker ahead of each handshake
   logic [1:0]          exp_bresp;
   logic [DATA_W-1:0]   exp_rdata;
   logic [1:0]          exp_rresp;
   logic                chk_r;
   logic                test_done;
   logic [15:0]         test_num;
   logic [31:0]         errors;

   int seed;
   int tests;
   int timeouts;
   bit timed_out;

   always #50 i_clk = ~i_clk;

   bsx_top #(.W(W)) i_bsx_top (
      .i_clk, .i_rst,
      .i_awvalid, .o_awready, .i_awaddr,
      .i_wvalid, .o_wready, .i_wdata, .i_wstrb,
      .o_bvalid, .i_bready, .o_bresp,
      .i_arvalid, .o_arready, .i_araddr,
      .o_rvalid, .i_rready, .o_rdata, .o_rresp
   );

   bsx_checker u_checker (
      .i_clk, .i_rst,
      .i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp),
      .i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata), .i_rresp(o_rresp),
      .i_exp_bresp(exp_bresp), .i_exp_rdata(exp_rdata), .i_exp_rresp(exp_rresp),
      .i_chk_r(chk_r), .i_test_done(test_done), .i_test_num(test_num),
      .o_errors(errors)
   );

   task automatic report_timeout(input string what);
      $display("timeout: %s did not complete within %0d cycles", what, TIMEOUT);
      timed_out = 1'b1;
      timeouts++;
   endtask

   // address and data are offered together and the response is taken after a random delay
   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
      int n;
      int d;
      bit got;
      if (timed_out) return;
      @(posedge i_clk);
      #1;
      i_awaddr  = addr;
      i_wdata   = data;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      exp_bresp = resp;
      n = 0;
      got = 1'b0;
      do begin
         @(posedge i_clk);
         got = o_awready && o_wready;
         n++;
      end while (!got && n < TIMEOUT);
      #1;
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      if (!got) begin
         report_timeout("write address and data accept");
         return;
      end
      d = $unsigned($random(seed)) % 4;
      repeat (d) @(posedge i_clk);
      #1;
      i_bready = 1'b1;
      n = 0;
      got = 1'b0;
      do begin
         @(posedge i_clk);
         got = o_bvalid;
         n++;
      end while (!got && n < TIMEOUT);
      #1;
      i_bready = 1'b0;
      if (!got) report_timeout("write response");
   endtask

   // check low means the checker ignores the data, as for STATUS polling
   task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] resp, input logic check,
                           output logic [31:0] data);
      int n;
      int d;
      bit got;
      data = '0;
      if (timed_out) return;
      @(posedge i_clk);
      #1;
      i_araddr  = addr;
      i_arvalid = 1'b1;
      exp_rdata = exp_data;
      exp_rresp = resp;
      chk_r     = check;
      n = 0;
      got = 1'b0;
      do begin
         @(posedge i_clk);
         got = o_arready;
         n++;
      end while (!got && n < TIMEOUT);
      #1;
      i_arvalid = 1'b0;
      if (!got) begin
         report_timeout("read address accept");
         return;
      end
      d = $unsigned($random(seed)) % 4;
      repeat (d) @(posedge i_clk);
      #1;
      i_rready = 1'b1;
      n = 0;
      got = 1'b0;
      do begin
         @(posedge i_clk);
         got = o_rvalid;
         data = o_rdata;
         n++;
      end while (!got && n < TIMEOUT);
      #1;
      i_rready = 1'b0;
      if (!got) report_timeout("read data");
   endtask

   // done is bit 1 of STATUS
   task automatic poll_done();
      logic [31:0] st;
      int n;
      n = 0;
      st = '0;
      do begin
         axi_read(REG_STATUS, 32'h0, OKAY, 1'b0, st);
         n++;
      end while (!timed_out && !st[1] && n < POLL_LIMIT);
      if (!timed_out && !st[1]) report_timeout("STATUS done polling");
   endtask

   task automatic finish_test();
      @(posedge i_clk);
      #1;
      test_num  = 16'(tests);
      test_done = 1'b1;
      @(posedge i_clk);
      #1;
      test_done = 1'b0;
      tests++;
   endtask

   initial begin
      int fd;
      string line;
      logic [31:0] kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] op;
      logic [31:0] res;
      logic [31:0] flags;
      logic [31:0] resp;
      logic [31:0] rd;
      seed      = 32'h11196819;
      tests     = 0;
      timeouts  = 0;
      timed_out = 1'b0;
      i_clk     = 1'b0;
      i_rst     = 1'b1;
      i_awvalid = 1'b0;
      i_awaddr  = '0;
      i_wvalid  = 1'b0;
      i_wdata   = '0;
      i_wstrb   = '1;
      i_bready  = 1'b0;
      i_arvalid = 1'b0;
      i_araddr  = '0;
      i_rready  = 1'b0;
      exp_bresp = OKAY;
      exp_rdata = '0;
      exp_rresp = OKAY;
      chk_r     = 1'b0;
      test_done = 1'b0;
      test_num  = '0;
      repeat (16) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      fd = $fopen("verification/bsx_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file verification/bsx_trace.txt");
         timed_out = 1'b1;
      end
      while (fd != 0 && !timed_out && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // comment and blank lines do not scan to seven fields
         if ($sscanf(line, "%h %h %h %h %h %h %h", kind, a, b, op, res, flags, resp) == 7) begin
            case (kind)
               0: begin
                  axi_write(REG_A, a, OKAY);
                  axi_write(REG_B, b, OKAY);
                  axi_write(REG_CMD, op, resp[1:0]);
                  poll_done();
               end
               // refused command or a write to an unmapped offset
               1: axi_write(REG_CMD, op, resp[1:0]);
               2: axi_write(a[7:0], b, resp[1:0]);
               3: axi_read(a[7:0], res, resp[1:0], 1'b1, rd);
               // second command and an operand write land while the first runs
               // the refused command asks for SUB so a wrongly taken one shows in the result
               4: begin
                  axi_write(REG_A, a, OKAY);
                  axi_write(REG_B, b, OKAY);
                  axi_write(REG_CMD, op, OKAY);
                  axi_write(REG_CMD, 32'(OP_SUB), resp[1:0]);
                  axi_write(REG_A, b, resp[1:0]);
                  poll_done();
               end
               default: $display("unknown trace kind %0d skipped", kind);
            endcase
            if (kind != 3) begin
               axi_read(REG_RESULT, res, OKAY, 1'b1, rd);
               axi_read(REG_STATUS, flags, OKAY, 1'b1, rd);
            end
            if (!timed_out) finish_test();
         end
      end
      if (fd != 0) $fclose(fd);
      $display("tests %0d, mismatches %0d, timeouts %0d", tests, errors, timeouts);
      if (errors == 0 && !timed_out && tests > 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: verification/bsx_checker.sv
`timescale 1ns/1ps

module bsx_checker import bsx_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_bvalid,
   input  logic              i_bready,
   input  logic [1:0]        i_bresp,
   input  logic              i_rvalid,
   input  logic              i_rready,
   input  logic [DATA_W-1:0] i_rdata,
   input  logic [1:0]        i_rresp,
   input  logic [1:0]        i_exp_bresp,
   input  logic [DATA_W-1:0] i_exp_rdata,
   input  logic [1:0]        i_exp_rresp,
   input  logic              i_chk_r,
   input  logic              i_test_done,
   input  logic [15:0]       i_test_num,
   output logic [31:0]       o_errors
);

   int total_errs;
   int test_errs;

   assign o_errors = 32'(total_errs);

   initial begin
      total_errs = 0;
      test_errs  = 0;
   end

   always @(posedge i_clk) begin
      if (!i_rst) begin
         // every write response is compared
         if (i_bvalid && i_bready && i_bresp !== i_exp_bresp) begin
            $display("[ERROR] %0t o_bresp expected %h got %h", $time, i_exp_bresp, i_bresp);
            test_errs++;
            total_errs++;
         end
         // read data is compared only when the testbench asks for it
         if (i_rvalid && i_rready && i_chk_r) begin
            if (i_rdata !== i_exp_rdata) begin
               $display("[ERROR] %0t o_rdata expected %h got %h", $time, i_exp_rdata, i_rdata);
               test_errs++;
               total_errs++;
            end
            if (i_rresp !== i_exp_rresp) begin
               $display("[ERROR] %0t o_rresp expected %h got %h", $time, i_exp_rresp, i_rresp);
               test_errs++;
               total_errs++;
            end
         end
         if (i_test_done) begin
            if (test_errs == 0) $display("test %0d ok", i_test_num);
            else $display("test %0d failed with %0d mismatches", i_test_num, test_errs);
            test_errs = 0;
         end
      end
   end

endmodule

// File: rtl/bsx_top.sv
`timescale 1ns/1ps

module bsx_top import bsx_pkg::*; #(
   parameter int W = 1
) (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_awvalid,
   output logic                o_awready,
   input  logic [7:0]          i_awaddr,
   input  logic                i_wvalid,
   output logic                o_wready,
   input  logic [DATA_W-1:0]   i_wdata,
   input  logic [DATA_W/8-1:0] i_wstrb,
   output logic                o_bvalid,
   input  logic                i_bready,
   output logic [1:0]          o_bresp,
   input  logic                i_arvalid,
   output logic                o_arready,
   input  logic [7:0]          i_araddr,
   output logic                o_rvalid,
   input  logic                i_rready,
   output logic [DATA_W-1:0]   o_rdata,
   output logic [1:0]          o_rresp
);

   logic              start;
   logic              busy;
   bsx_cmd_t          cmd;
   bsx_flags_t        flags;
   logic [DATA_W-1:0] result;
   logic              cnt_en;
   logic              cnt0;
   logic              cnt_done;
   logic [W-1:0]      res_bits;
   logic              cmp;
   logic              carry;

   // host side register file and start control
   bsx_axil_regs #(.W(W)) u_regs (
      .i_clk, .i_rst,
      .i_awvalid, .o_awready, .i_awaddr,
      .i_wvalid, .o_wready, .i_wdata, .i_wstrb,
      .o_bvalid, .i_bready, .o_bresp,
      .i_arvalid, .o_arready, .i_araddr,
      .o_rvalid, .i_rready, .o_rdata, .o_rresp,
      .o_start(start), .o_cmd(cmd), .i_busy(busy),
      .i_flags(flags), .i_result(result)
   );

   // bit counter shared by the ALU and the collector
   bsx_sequencer #(.W(W)) u_seq (
      .i_clk, .i_rst, .i_start(start),
      .o_cnt_en(cnt_en), .o_cnt0(cnt0), .o_cnt_done(cnt_done), .o_busy(busy)
   );

   bsx_serial_alu #(.W(W)) u_alu (
      .i_clk, .i_rst, .i_start(start), .i_cmd(cmd),
      .i_cnt_en(cnt_en), .i_cnt0(cnt0), .i_cnt_done(cnt_done),
      .o_res_bits(res_bits), .o_cmp(cmp), .o_carry(carry)
   );

   // reassembles the serial bits into the word read back over RESULT
   bsx_result_collector #(.W(W)) u_coll (
      .i_clk, .i_rst, .i_start(start),
      .i_cnt_en(cnt_en), .i_cnt_done(cnt_done),
      .i_res_bits(res_bits), .i_cmp(cmp), .i_carry(carry),
      .o_result(result), .o_flags(flags)
   );

endmodule

// File: rtl/bsx_result_collector.sv
`timescale 1ns/1ps

module bsx_result_collector import bsx_pkg::*; #(
   parameter int W = 1
) (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_start,
   input  logic              i_cnt_en,
   input  logic              i_cnt_done,
   input  logic [W-1:0]      i_res_bits,
   input  logic              i_cmp,
   input  logic              i_carry,
   output logic [DATA_W-1:0] o_result,
   output bsx_flags_t        o_flags
);

   logic [DATA_W-1:0] shift_q;
   logic [DATA_W-1:0] shift_d;
   logic [DATA_W-1:0] final_val;

   // new bits enter at the top so the first step ends up in the low bits
   assign shift_d = {i_res_bits, shift_q[DATA_W-1:W]};

   // compares leave all data bits at zero and contribute only bit 0
   assign final_val = {shift_d[DATA_W-1:1], shift_d[0] | i_cmp};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         shift_q  <= '0;
         o_result <= '0;
         o_flags  <= '0;
      end else begin
         if (i_cnt_en) begin
            shift_q <= shift_d;
         end
         if (i_start) begin
            o_flags.done <= 1'b0;
         end
         // the last step is folded in directly so the value is ready one cycle later
         if (i_cnt_done) begin
            o_result      <= final_val;
            o_flags.zero  <= (final_val == '0);
            o_flags.carry <= i_carry;
            o_flags.done  <= 1'b1;
         end
      end
   end

   // start and the final step can never meet in one cycle
   no_start_at_done: assert property (@(posedge i_clk) disable iff (i_rst)
      i_cnt_done |-> !i_start);

endmodule

// File: rtl/bsx_serial_alu.sv
`timescale 1ns/1ps

module bsx_serial_alu import bsx_pkg::*; #(
   parameter int W = 1
) (
   input  logic         i_clk,
   input  logic         i_rst,
   input  logic         i_start,
   input  bsx_cmd_t     i_cmd,
   input  logic         i_cnt_en,
   input  logic         i_cnt0,
   input  logic         i_cnt_done,
   output logic [W-1:0] o_res_bits,
   output logic         o_cmp,
   output logic         o_carry
);

   bsx_op_e           op_q;
   logic [DATA_W-1:0] a_sr;
   logic [DATA_W-1:0] b_sr;
   logic              carry_q;
   logic [W-1:0]      a_w;
   logic [W-1:0]      b_w;
   logic [W-1:0]      b_eff;
   logic [W-1:0]      sum;
   logic              sub_op;
   logic              arith_op;
   logic              cin;
   logic              cout;
   logic              slt_bit;

   // the low W bits of each operand are consumed every active cycle
   assign a_w = a_sr[W-1:0];
   assign b_w = b_sr[W-1:0];

   // subtract and both compares compute a + ~b + 1
   assign sub_op   = (op_q == OP_SUB) | (op_q == OP_SLT) | (op_q == OP_SLTU);
   assign arith_op = sub_op | (op_q == OP_ADD);
   assign b_eff    = sub_op ? ~b_w : b_w;

   // the first step seeds the carry with the +1 of the two's complement
   assign cin = i_cnt0 ? sub_op : carry_q;
   assign {cout, sum} = {1'b0, a_w} + {1'b0, b_eff} + (W+1)'(cin);

   // with equal signs the difference cannot overflow and its sign decides
   assign slt_bit = (a_w[W-1] ^ b_w[W-1]) ? a_w[W-1] : sum[W-1];

   always_comb begin
      case (op_q)
         OP_ADD, OP_SUB: o_res_bits = sum;
         OP_AND:         o_res_bits = a_w & b_w;
         OP_OR:          o_res_bits = a_w | b_w;
         OP_XOR:         o_res_bits = a_w ^ b_w;
         // compares put their answer in bit 0 through o_cmp at the end
         default:        o_res_bits = '0;
      endcase
   end

   // unsigned less-than is a missing carry out of a + ~b + 1
   assign o_cmp   = i_cnt_done & (((op_q == OP_SLT) & slt_bit) | ((op_q == OP_SLTU) & ~cout));
   assign o_carry = i_cnt_done & arith_op & cout;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         op_q    <= OP_ADD;
         a_sr    <= '0;
         b_sr    <= '0;
         carry_q <= 1'b0;
      end else if (i_start) begin
         op_q    <= i_cmd.op;
         a_sr    <= i_cmd.a;
         b_sr    <= i_cmd.b;
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         a_sr    <= a_sr >> W;
         b_sr    <= b_sr >> W;
         carry_q <= cout;
      end
   end

   // the first and last step markers only arrive inside an enabled run
   step_in_run: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_cnt0 || i_cnt_done) |-> i_cnt_en);

endmodule

// File: rtl/bsx_sequencer.sv
`timescale 1ns/1ps

module bsx_sequencer import bsx_pkg::*; #(
   parameter int W = 1
) (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_start,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done,
   output logic o_busy
);

   // the upper counter walks groups of four bits with W=1 and single steps with W=4
   localparam int HI_W = $clog2(DATA_W/4);

   logic [HI_W-1:0] cnt_hi;

   // busy drops in the cycle that follows the last step
   assign o_busy = i_start | o_cnt_en;

   generate
      if (W == 1) begin : g_ring
         // cnt_r is a four bit ring that carries a single token
         // each time the token leaves bit 3 the upper counter advances
         // a running count is simply a non-empty ring, so no separate enable FF
         logic [3:0] cnt_r;

         always_ff @(posedge i_clk) begin
            if (i_rst) begin
               cnt_r  <= 4'b0000;
               cnt_hi <= '0;
            end else begin
               cnt_hi <= cnt_hi + HI_W'(cnt_r[3]);
               // the token is injected on start and blocked from re-entering at done
               cnt_r  <= {cnt_r[2:0], (cnt_r[3] & ~o_cnt_done) | (i_start & ~o_cnt_en)};
            end
         end

         assign o_cnt_en   = |cnt_r;
         assign o_cnt0     = (cnt_hi == '0) & cnt_r[0];
         assign o_cnt_done = (&cnt_hi) & cnt_r[3];
      end else if (W == 4) begin : g_step
         // four bits per cycle leaves DATA_W/4 steps for a plain counter
         always_ff @(posedge i_clk) begin
            if (i_rst) begin
               o_cnt_en <= 1'b0;
               cnt_hi   <= '0;
            end else begin
               if (i_start) begin
                  o_cnt_en <= 1'b1;
               end else if (o_cnt_done) begin
                  o_cnt_en <= 1'b0;
               end
               // the counter wraps back to zero on the last step
               cnt_hi <= cnt_hi + HI_W'(o_cnt_en);
            end
         end

         assign o_cnt0     = o_cnt_en & (cnt_hi == '0);
         assign o_cnt_done = o_cnt_en & (&cnt_hi);
      end else begin : g_bad_w
         $fatal(1, "bsx_sequencer supports W of 1 or 4 only");
      end
   endgenerate

   // a new command must wait until the running one has finished
   start_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_start |-> !o_cnt_en);

   // every run is exactly DATA_W/W active cycles long
   run_length: assert property (@(posedge i_clk) disable iff (i_rst)
      o_cnt0 |-> ##(DATA_W/W - 1) o_cnt_done);

endmodule

// File: rtl/bsx_axil_regs.sv
`timescale 1ns/1ps

module bsx_axil_regs import bsx_pkg::*; #(
   parameter int W = 1
) (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_awvalid,
   output logic                  o_awready,
   input  logic [7:0]            i_awaddr,
   input  logic                  i_wvalid,
   output logic                  o_wready,
   input  logic [DATA_W-1:0]     i_wdata,
   input  logic [DATA_W/8-1:0]   i_wstrb,
   output logic                  o_bvalid,
   input  logic                  i_bready,
   output logic [1:0]            o_bresp,
   input  logic                  i_arvalid,
   output logic                  o_arready,
   input  logic [7:0]            i_araddr,
   output logic                  o_rvalid,
   input  logic                  i_rready,
   output logic [DATA_W-1:0]     o_rdata,
   output logic [1:0]            o_rresp,
   output logic                  o_start,
   output bsx_cmd_t              o_cmd,
   input  logic                  i_busy,
   input  bsx_flags_t            i_flags,
   input  logic [DATA_W-1:0]     i_result
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
   typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

   wr_state_e         wr_state;
   rd_state_e         rd_state;
   logic              wr_accept;
   logic              rd_accept;
   logic [DATA_W-1:0] a_q;
   logic [DATA_W-1:0] b_q;
   logic [DATA_W-1:0] a_merged;
   logic [DATA_W-1:0] b_merged;
   bsx_op_e           op_q;
   logic              start_q;
   logic [1:0]        bresp_q;
   logic [1:0]        rresp_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] status;

   // address and data are taken in the same cycle, and only with no B response waiting
   assign wr_accept = (wr_state == WR_IDLE) & i_awvalid & i_wvalid;
   assign o_awready = wr_accept;
   assign o_wready  = wr_accept;
   assign o_bvalid  = (wr_state == WR_RESP);
   assign o_bresp   = bresp_q;

   assign rd_accept = (rd_state == RD_IDLE) & i_arvalid;
   assign o_arready = rd_accept;
   assign o_rvalid  = (rd_state == RD_RESP);
   assign o_rdata   = rdata_q;
   assign o_rresp   = rresp_q;

   assign o_start = start_q;
   assign o_cmd   = '{op: op_q, a: a_q, b: b_q};

   // done is hidden while busy so a poll right after CMD never sees the old result
   assign status = {{(DATA_W-4){1'b0}}, i_flags.carry, i_flags.zero,
                    i_flags.done & ~i_busy, i_busy};

   // byte strobes apply to the operand registers
   always_comb begin
      a_merged = a_q;
      b_merged = b_q;
      for (int i = 0; i < DATA_W/8; i++) begin
         if (i_wstrb[i]) begin
            a_merged[8*i +: 8] = i_wdata[8*i +: 8];
            b_merged[8*i +: 8] = i_wdata[8*i +: 8];
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_state <= WR_IDLE;
         bresp_q  <= RESP_OKAY;
         a_q      <= '0;
         b_q      <= '0;
         op_q     <= OP_ADD;
         start_q  <= 1'b0;
      end else begin
         // the start strobe lasts exactly one cycle
         start_q <= 1'b0;
         case (wr_state)
            WR_IDLE: begin
               if (wr_accept) begin
                  wr_state <= WR_RESP;
                  bresp_q  <= RESP_OKAY;
                  case (i_awaddr)
                     REG_A: begin
                        if (i_busy) bresp_q <= RESP_SLVERR;
                        else a_q <= a_merged;
                     end
                     REG_B: begin
                        if (i_busy) bresp_q <= RESP_SLVERR;
                        else b_q <= b_merged;
                     end
                     REG_CMD: begin
                        // a busy datapath or the unused opcode refuses the command
                        if (i_busy || i_wdata[2:0] == 3'd7) begin
                           bresp_q <= RESP_SLVERR;
                        end else begin
                           op_q    <= bsx_op_e'(i_wdata[2:0]);
                           start_q <= 1'b1;
                        end
                     end
                     // status and result are read only and a write leaves them alone
                     REG_STATUS, REG_RESULT: bresp_q <= RESP_OKAY;
                     default: bresp_q <= RESP_SLVERR;
                  endcase
               end
            end
            WR_RESP: if (i_bready) wr_state <= WR_IDLE;
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_state <= RD_IDLE;
         rresp_q  <= RESP_OKAY;
         rdata_q  <= '0;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (rd_accept) begin
                  rd_state <= RD_RESP;
                  rresp_q  <= RESP_OKAY;
                  case (i_araddr)
                     REG_A:      rdata_q <= a_q;
                     REG_B:      rdata_q <= b_q;
                     REG_CMD:    rdata_q <= {{(DATA_W-3){1'b0}}, op_q};
                     REG_STATUS: rdata_q <= status;
                     REG_RESULT: rdata_q <= i_result;
                     default: begin
                        rdata_q <= '0;
                        rresp_q <= RESP_SLVERR;
                     end
                  endcase
               end
            end
            RD_RESP: if (i_rready) rd_state <= RD_IDLE;
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   // the B response may not be withdrawn before the master takes it
   bvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

   // a started operation reports done one cycle after its last serial step
   done_latency: assert property (@(posedge i_clk) disable iff (i_rst)
      o_start |-> ##(DATA_W/W + 1) i_flags.done);

endmodule

// File: rtl/bsx_pkg.sv
package bsx_pkg;

   // operands and results are one bus word wide
   localparam int DATA_W = 32;

   // byte offsets of the registers on the AXI4-Lite port
   localparam logic [7:0] REG_A      = 8'h00;
   localparam logic [7:0] REG_B      = 8'h04;
   localparam logic [7:0] REG_CMD    = 8'h08;
   localparam logic [7:0] REG_STATUS = 8'h0C;
   localparam logic [7:0] REG_RESULT = 8'h10;

   // opcode as written into the low three bits of CMD
   // the code 3'd7 has no operation behind it and is refused by the slave
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLTU = 3'd6
   } bsx_op_e;

   // command handed from the register slave to the serial datapath
   // it is only sampled by the ALU while the start strobe is high
   typedef struct packed {
      bsx_op_e           op;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
   } bsx_cmd_t;

   // completion flags handed from the collector back to the slave
   // zero and carry describe the last finished operation
   typedef struct packed {
      logic done;
      logic zero;
      logic carry;
   } bsx_flags_t;

endpackage
